// ==== decExTb.sv ====
`timescale 1ns/1ps

module decExTb
    import rvPipePkg::*;
();

    typedef struct packed {
        logic [xlen-1:0]     pc;
        logic [regAddrW-1:0] rd;
        logic [xlen-1:0]     value;
        logic                regWrite;
        logic                valueKnown; // Low for branches and unknown opcodes
    } expT;

    localparam int aluCount   = 200;
    localparam int bpCount    = 300;
    localparam int brCount    = 200;
    localparam int jmpCount   = 200;
    localparam int immCount   = 150;
    localparam int totalInstr = aluCount + bpCount + brCount + jmpCount + immCount;
    localparam int watchdogNs = totalInstr * 3 * 40 * 8;

    logic        clk;
    logic        rstN;
    fetchPktT    instr;
    logic        instrValid;
    logic        instrReady;
    resultPktT   result;
    logic        resultValid;
    logic        resultReady;
    int          seed = 71;
    int          errCount = 0;
    int          checkCount = 0;
    int          sentTotal = 0;
    logic        inFire = 1'b0;
    logic [31:0] genPc;
    logic [31:0] genTarget;
    logic        jumpPending;
    int          wrongLeft;
    logic        modelPend;
    logic [31:0] modelTarget;
    expT         expQ[$];

    decExTop dut0 (
        .clk         (clk),
        .rstN        (rstN),
        .instr       (instr),
        .instrValid  (instrValid),
        .instrReady  (instrReady),
        .result      (result),
        .resultValid (resultValid),
        .resultReady (resultReady)
    );

    bind decExTop decEx_checker chk0 (
        .clk         (clk),
        .rstN        (rstN),
        .instrReady  (instrReady),
        .decValid    (decValid),
        .exValid     (exValid),
        .result      (result),
        .resultValid (resultValid),
        .resultReady (resultReady)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        #(watchdogNs);
        $display("Timeout: the pipeline stopped producing results");
        $display("Errors found");
        $finish;
    end

    // ============================================================
    // Random helpers and instruction encoders
    // ============================================================
    function automatic int unsigned pick(input int unsigned n);
        logic [31:0] r;
        r = $random(seed);
        pick = r % n;
    endfunction

    function automatic logic [31:0] iWord(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] op);
        iWord = {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] aluWord(input logic [31:0] r);
        logic [2:0]  f3;
        logic [11:0] imm;
        f3 = r[3:1];
        if (r[0]) begin // R-type with funct7 set only for SUB and SRA
            aluWord = {((f3 == 3'd0 || f3 == 3'd5) && r[4]) ? 7'b0100000 : 7'b0,
                       r[19:15], r[14:10], f3, r[9:5], opR};
        end else begin
            imm = r[31:20];
            if (f3 == 3'd1) imm = {7'b0, r[24:20]};
            if (f3 == 3'd5) imm = {1'b0, r[4], 5'b0, r[24:20]};
            aluWord = iWord(imm, r[14:10], f3, r[9:5], opImm);
        end
    endfunction

    function automatic logic [2:0] brFunct(input logic [2:0] s);
        brFunct = (s[2:1] == 2'b01) ? {2'b00, s[0]} : s; // Skip the two reserved codes
    endfunction

    function automatic logic [6:0] unknownOp(input logic [1:0] s);
        case (s)
            2'd0:    unknownOp = 7'b0000011;
            2'd1:    unknownOp = 7'b0100011;
            2'd2:    unknownOp = 7'b1110011;
            default: unknownOp = 7'b0001111;
        endcase
    endfunction

    // ============================================================
    // Reference model from the RV32I rules
    // ============================================================
    function automatic logic [31:0] aluRef(input logic [2:0] f3, input logic alt,
                                           input logic [31:0] a, input logic [31:0] b);
        logic [31:0] res;
        case (f3)
            3'd0: res = alt ? a - b : a + b;
            3'd1: res = a << b[4:0];
            3'd2: res = {31'b0, $signed(a) < $signed(b)};
            3'd3: res = {31'b0, a < b};
            3'd4: res = a ^ b;
            3'd5: begin
                if (alt) res = $signed(a) >>> b[4:0];
                else res = a >> b[4:0];
            end
            3'd6: res = a | b;
            default: res = a & b;
        endcase
        aluRef = res;
    endfunction

    function automatic logic branchTaken(input logic [2:0] f3, input logic [31:0] a,
                                         input logic [31:0] b);
        case (f3)
            3'd0:    branchTaken = a == b;
            3'd1:    branchTaken = a != b;
            3'd4:    branchTaken = $signed(a) < $signed(b);
            3'd5:    branchTaken = $signed(a) >= $signed(b);
            3'd6:    branchTaken = a < b;
            3'd7:    branchTaken = a >= b;
            default: branchTaken = 1'b0;
        endcase
    endfunction

    function automatic void refExec(input logic [31:0] w, input logic [31:0] pc,
                                    input logic [31:0] a, input logic [31:0] b,
                                    output expT e, output logic tk, output logic [31:0] tgt);
        logic [31:0] immI;
        logic [31:0] immU;
        immI = {{20{w[31]}}, w[31:20]};
        immU = {w[31:12], 12'b0};
        e.pc = pc;
        e.rd = w[11:7];
        e.value = '0;
        e.regWrite = (w[11:7] != 5'd0);
        e.valueKnown = 1'b1;
        tk = 1'b0;
        tgt = '0;
        case (w[6:0])
            opR:     e.value = aluRef(w[14:12], w[30], a, b);
            opImm:   e.value = aluRef(w[14:12], (w[14:12] == 3'd5) && w[30], a, immI);
            opLui:   e.value = immU;
            opAuipc: e.value = pc + immU;
            opJal: begin
                e.value = pc + 32'd4;
                tk = 1'b1;
                tgt = pc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            end
            opJalr: begin
                e.value = pc + 32'd4;
                tk = 1'b1;
                tgt = (a + immI) & ~32'd1;
            end
            opBranch: begin
                e.regWrite = 1'b0;
                e.valueKnown = 1'b0;
                tk = branchTaken(w[14:12], a, b);
                tgt = pc + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            end
            default: begin
                e.regWrite = 1'b0;
                e.valueKnown = 1'b0;
            end
        endcase
    endfunction

    task automatic modelAccept(input fetchPktT p);
        expT         e;
        logic        tk;
        logic [31:0] tgt;
        if (!modelPend || p.pc == modelTarget) begin // Wrong-path packets vanish
            refExec(p.word, p.pc, p.rs1Val, p.rs2Val, e, tk, tgt);
            expQ.push_back(e);
            modelPend = tk;
            modelTarget = tgt;
        end
    endtask

    // ============================================================
    // Stimulus
    // ============================================================
    task automatic genInstr(input int kind, output fetchPktT p);
        logic [31:0] r;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] w;
        logic [31:0] tgt;
        logic        tk;
        expT         e;
        int unsigned sel;
        r = $random(seed);
        a = $random(seed);
        b = $random(seed);
        sel = pick(4);
        w = aluWord(r);
        if (kind == 1 && sel < 2) begin
            if (r[21:20] == 2'b00) b = a; // Equal operands now and then
            w = {1'b0, r[30:25], r[19:15], r[14:10], brFunct(r[24:22]),
                 r[11:8], 1'b0, opBranch};
            w[27:25] = w[27:25] | 3'b001; // Keeps the forward offset at 32 or more
        end else if (kind == 2 && sel == 1) begin
            w = {1'b0, r[30:21], 1'b0, r[19:12], r[9:5], opJal};
            w[25] = 1'b1; // Forward offset of 32 or more
        end else if (kind == 2 && sel == 2) begin
            a = genPc + 32'd64 + pick(256) * 4 + 32'(r[25]); // Odd sum tests bit 0 clear
            w = iWord(12'(pick(16) * 4), r[14:10], 3'b000, r[9:5], opJalr);
        end else if (kind == 3 && sel == 1) begin
            w = {r[31:12], r[9:5], opLui};
        end else if (kind == 3 && sel == 2) begin
            w = {r[31:12], r[9:5], opAuipc};
        end else if (kind == 3 && sel == 3) begin
            w = {r[31:7], unknownOp(r[1:0])};
        end
        p = {w, genPc, a, b};
        if (jumpPending) begin
            wrongLeft--;
        end else begin
            refExec(w, genPc, a, b, e, tk, tgt);
            if (tk) begin
                jumpPending = 1'b1;
                wrongLeft = pick(4);
                genTarget = tgt;
            end
        end
        if (jumpPending && wrongLeft == 0) begin
            genPc = genTarget;
            jumpPending = 1'b0;
        end else begin
            genPc = genPc + 32'd4;
        end
    endtask

    // ============================================================
    // Checks and test sequencing
    // ============================================================
    task automatic compareField(input string name, input logic [31:0] exp,
                                input logic [31:0] got);
        assert (got === exp) else begin
            $display("FAILED %s: expected %h, got %h", name, exp, got);
            errCount++;
        end
    endtask

    task automatic checkResult;
        expT e;
        checkCount++;
        assert (expQ.size() != 0) else begin
            $display("A result for pc %h arrived with no instruction outstanding", result.pc);
            errCount++;
        end
        if (expQ.size() != 0) begin
            e = expQ.pop_front();
            compareField("result.pc", e.pc, result.pc);
            compareField("result.rd", 32'(e.rd), 32'(result.rd));
            compareField("result.regWrite", 32'(e.regWrite), 32'(result.regWrite));
            if (e.valueKnown) compareField("result.value", e.value, result.value);
        end
    endtask

    task automatic stepCycle(input int kind, input logic feed, input int unsigned readyPct);
        fetchPktT p;
        @(negedge clk);
        if (inFire) instrValid = 1'b0;
        if (feed && !instrValid && pick(8) != 0) begin
            genInstr(kind, p);
            instr = p;
            instrValid = 1'b1;
        end
        resultReady = (pick(100) < readyPct);
        #1;
        if (resultValid && resultReady) checkResult();
        inFire = instrValid && instrReady;
        if (inFire) begin
            modelAccept(instr);
            sentTotal++;
        end
    endtask

    task automatic runTest(input string name, input int kind, input int count,
                           input int unsigned readyPct);
        int goal;
        int idle;
        int c0;
        int e0;
        goal = sentTotal + count;
        c0 = checkCount;
        e0 = errCount;
        while (sentTotal < goal) stepCycle(kind, 1'b1, readyPct);
        idle = 0;
        while (expQ.size() != 0 && idle < 40) begin
            stepCycle(kind, 1'b0, 100);
            idle++;
        end
        assert (expQ.size() == 0) else begin
            $display("%0d expected results never arrived in test %s", expQ.size(), name);
            errCount++;
            expQ.delete();
        end
        repeat (4) stepCycle(kind, 1'b0, 100); // Catch stray results
        $display("Test %s: %0d results, %0d errors", name, checkCount - c0, errCount - e0);
    endtask

    initial begin
        rstN = 1'b0;
        instr = '0;
        instrValid = 1'b0;
        resultReady = 1'b0;
        genPc = 32'h0000_1000;
        genTarget = '0;
        jumpPending = 1'b0;
        wrongLeft = 0;
        modelPend = 1'b0;
        modelTarget = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        #1;
        compareField("resultValid", 32'd0, 32'(resultValid));
        compareField("instrReady", 32'd1, 32'(instrReady));
        @(negedge clk);
        rstN = 1'b1;
        #1;
        compareField("resultValid", 32'd0, 32'(resultValid));
        compareField("instrReady", 32'd1, 32'(instrReady));
        $display("Test reset: %0d errors", errCount);
        runTest("alu", 0, aluCount, 100);
        runTest("backpressure", 0, bpCount, 50);
        runTest("branch", 1, brCount, 75);
        runTest("jump", 2, jmpCount, 75);
        runTest("upperImm", 3, immCount, 90);
        $display("Summary: 6 tests, %0d results checked, %0d errors", checkCount, errCount);
        if (errCount == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== decExTop.sv ====
`timescale 1ns/1ps

module decExTop
    import rvPipePkg::*;
(
    input  logic      clk,
    input  logic      rstN,
    input  fetchPktT  instr,
    input  logic      instrValid,
    output logic      instrReady,
    output resultPktT result,
    output logic      resultValid,
    input  logic      resultReady
);

    decPktT dec;
    logic   decValid;
    logic   decReady;
    decPktT ex;
    logic   exValid;
    logic   exReady;

    // ============================================================
    // Decode -> ID/EX register -> execute
    // ============================================================
    instrDecoder decoder0 (
        .clk        (clk),
        .rstN       (rstN),
        .instr      (instr),
        .instrValid (instrValid),
        .instrReady (instrReady),
        .dec        (dec),
        .decValid   (decValid),
        .decReady   (decReady)
    );

    idExReg idEx0 (
        .clk      (clk),
        .rstN     (rstN),
        .dec      (dec),
        .decValid (decValid),
        .decReady (decReady),
        .ex       (ex),
        .exValid  (exValid),
        .exReady  (exReady)
    );

    execUnit exec0 (
        .clk         (clk),
        .rstN        (rstN),
        .ex          (ex),
        .exValid     (exValid),
        .exReady     (exReady),
        .result      (result),
        .resultValid (resultValid),
        .resultReady (resultReady)
    );

endmodule

// ==== decEx_checker.sv ====
`timescale 1ns/1ps

module decEx_checker
    import rvPipePkg::*;
(
    input logic      clk,
    input logic      rstN,
    input logic      instrReady,
    input logic      decValid,
    input logic      exValid,
    input resultPktT result,
    input logic      resultValid,
    input logic      resultReady
);

    // ============================================================
    // Top-level handshake rules
    // ============================================================
    resultIdleAfterReset: assert property (
        @(posedge clk) !rstN |=> !resultValid
    ) else $error("resultValid high in the cycle after reset");

    // Stalled result must hold valid and payload
    resultHeld: assert property (
        @(posedge clk) disable iff (!rstN)
        resultValid && !resultReady |=> resultValid && $stable(result)
    ) else $error("result changed or dropped while stalled");

    // Full pipe keeps the input closed while the stall lasts
    fullPipeStall: assert property (
        @(posedge clk) disable iff (!rstN)
        !resultReady && resultValid && exValid && decValid |=> resultReady || !instrReady
    ) else $error("instrReady rose while the full pipe was still stalled");

endmodule

// ==== execUnit.sv ====
`timescale 1ns/1ps

module execUnit
    import rvPipePkg::*;
(
    input  logic      clk,
    input  logic      rstN,
    input  decPktT    ex,
    input  logic      exValid,
    output logic      exReady,
    output resultPktT result,
    output logic      resultValid,
    input  logic      resultReady
);

    logic [xlen-1:0] opB;
    logic [4:0]      shamt;
    logic [xlen-1:0] aluOut;
    logic [xlen-1:0] wbValue;
    logic [xlen-1:0] target;
    logic            brCond;
    logic            taken;
    logic            squash;
    logic            accept;
    logic            pendValid;
    logic [xlen-1:0] pendTarget;

    // ============================================================
    // ALU
    // ============================================================
    assign opB   = ex.aluSrcImm ? ex.imm : ex.rs2Val;
    assign shamt = opB[4:0];

    always_comb begin
        case (ex.aluOp)
            aluAdd:  aluOut = ex.rs1Val + opB;
            aluSub:  aluOut = ex.rs1Val - opB;
            aluSll:  aluOut = ex.rs1Val << shamt;
            aluSlt:  aluOut = {{(xlen-1){1'b0}}, $signed(ex.rs1Val) < $signed(opB)};
            aluSltu: aluOut = {{(xlen-1){1'b0}}, ex.rs1Val < opB};
            aluXor:  aluOut = ex.rs1Val ^ opB;
            aluSrl:  aluOut = ex.rs1Val >> shamt;
            aluSra:  aluOut = $signed(ex.rs1Val) >>> shamt;
            aluOr:   aluOut = ex.rs1Val | opB;
            aluAnd:  aluOut = ex.rs1Val & opB;
            default: aluOut = '0;
        endcase
    end

    always_comb begin
        case (ex.resultSel)
            selAlu:  wbValue = aluOut;
            selPc4:  wbValue = ex.pcPlus4;
            selImm:  wbValue = ex.imm;
            default: wbValue = aluOut;
        endcase
    end

    // ============================================================
    // Branch and jump resolution
    // ============================================================
    always_comb begin
        case (ex.branchFunct3)
            3'b000:  brCond = ex.rs1Val == ex.rs2Val;
            3'b001:  brCond = ex.rs1Val != ex.rs2Val;
            3'b100:  brCond = $signed(ex.rs1Val) < $signed(ex.rs2Val);
            3'b101:  brCond = $signed(ex.rs1Val) >= $signed(ex.rs2Val);
            3'b110:  brCond = ex.rs1Val < ex.rs2Val;
            3'b111:  brCond = ex.rs1Val >= ex.rs2Val;
            default: brCond = 1'b0;
        endcase
    end

    assign taken  = ex.isJal || ex.isJalr || (ex.isBranch && brCond);
    assign target = ex.isJalr ? ((ex.rs1Val + ex.imm) & ~xlen'(1)) : ex.pc + ex.imm;

    // Wrong path until the target pc shows up
    assign squash = pendValid && (ex.pc != pendTarget);

    // ============================================================
    // Result register and squash state
    // ============================================================
    assign exReady = !resultValid || resultReady;
    assign accept  = exValid && exReady;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            resultValid <= 1'b0;
            pendValid   <= 1'b0;
        end else if (accept && !squash) begin
            resultValid <= 1'b1;
            pendValid   <= taken; // Also clears on a target match
        end else if (exReady) begin
            resultValid <= 1'b0;  // Drained, or consumed a squashed packet
        end
    end

    always_ff @(posedge clk) begin
        if (accept && !squash) begin
            result.pc       <= ex.pc;
            result.rd       <= ex.rd;
            result.value    <= wbValue;
            result.regWrite <= ex.regWrite && (ex.rd != '0);
            if (taken) begin
                pendTarget <= target;
            end
        end
    end

endmodule

// ==== files.f ====
rvPipePkg.sv
instrDecoder.sv
idExReg.sv
execUnit.sv
decExTop.sv
decEx_checker.sv
decExTb.sv

// ==== idExReg.sv ====
`timescale 1ns/1ps

module idExReg
    import rvPipePkg::*;
(
    input  logic   clk,
    input  logic   rstN,
    input  decPktT dec,
    input  logic   decValid,
    output logic   decReady,
    output decPktT ex,
    output logic   exValid,
    input  logic   exReady
);

    logic load;

    // ============================================================
    // Decode/execute boundary
    // ============================================================
    // Empty or draining this cycle
    assign decReady = !exValid || exReady;
    assign load     = decValid && decReady;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            exValid <= 1'b0;
        end else if (decReady) begin
            exValid <= decValid; // Drops to 0 when drained with nothing behind
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            ex <= dec;
        end
    end

endmodule

// ==== instrDecoder.sv ====
`timescale 1ns/1ps

module instrDecoder
    import rvPipePkg::*;
(
    input  logic     clk,
    input  logic     rstN,
    input  fetchPktT instr,
    input  logic     instrValid,
    output logic     instrReady,
    output decPktT   dec,
    output logic     decValid,
    input  logic     decReady
);

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic            altFunct;
    logic [3:0]      aluFromFunct;
    logic [xlen-1:0] immI;
    logic [xlen-1:0] immU;
    logic [xlen-1:0] immJ;
    logic [xlen-1:0] immB;
    decPktT          decNext;

    // ============================================================
    // Field extraction
    // ============================================================
    assign opcode   = instr.word.r.opcode;
    assign funct3   = instr.word.r.funct3;
    assign altFunct = instr.word.r.funct7[5]; // SUB / SRA / SRAI

    assign immI = {{20{instr.word.i.imm12[11]}}, instr.word.i.imm12};
    assign immU = {instr.word.i.imm12, instr.word.i.rs1, instr.word.i.funct3, 12'b0};
    assign immJ = {{12{instr.word.i.imm12[11]}}, instr.word.i.rs1, instr.word.i.funct3,
                   instr.word.i.imm12[0], instr.word.i.imm12[10:1], 1'b0};
    assign immB = {{20{instr.word.i.imm12[11]}}, instr.word.i.rd[0],
                   instr.word.i.imm12[10:5], instr.word.i.rd[4:1], 1'b0};

    always_comb begin
        case (funct3)
            3'b000:  aluFromFunct = (opcode == opR && altFunct) ? aluSub : aluAdd;
            3'b001:  aluFromFunct = aluSll;
            3'b010:  aluFromFunct = aluSlt;
            3'b011:  aluFromFunct = aluSltu;
            3'b100:  aluFromFunct = aluXor;
            3'b101:  aluFromFunct = altFunct ? aluSra : aluSrl;
            3'b110:  aluFromFunct = aluOr;
            default: aluFromFunct = aluAnd;
        endcase
    end

    // ============================================================
    // Control decode
    // ============================================================
    always_comb begin
        decNext.pc           = instr.pc;
        decNext.rd           = instr.word.r.rd;
        decNext.aluOp        = aluAdd;
        decNext.aluSrcImm    = 1'b0;
        decNext.regWrite     = 1'b0;
        decNext.isBranch     = 1'b0;
        decNext.branchFunct3 = funct3;
        decNext.isJal        = 1'b0;
        decNext.isJalr       = 1'b0;
        decNext.resultSel    = selAlu;
        decNext.rs1Val       = instr.rs1Val;
        decNext.rs2Val       = instr.rs2Val;
        decNext.imm          = immI;
        decNext.pcPlus4      = instr.pc + xlen'(4);
        case (opcode)
            opR: begin
                decNext.aluOp    = aluFromFunct;
                decNext.regWrite = 1'b1;
            end
            opImm: begin
                decNext.aluOp     = aluFromFunct;
                decNext.aluSrcImm = 1'b1; // Shamt sits in imm[4:0]
                decNext.regWrite  = 1'b1;
            end
            opLui: begin
                decNext.regWrite  = 1'b1;
                decNext.resultSel = selImm;
                decNext.imm       = immU;
            end
            opAuipc: begin
                decNext.regWrite  = 1'b1;
                decNext.resultSel = selImm;
                decNext.imm       = instr.pc + immU; // pc folded in here
            end
            opJal: begin
                decNext.regWrite  = 1'b1;
                decNext.isJal     = 1'b1;
                decNext.resultSel = selPc4;
                decNext.imm       = immJ;
            end
            opJalr: begin
                decNext.regWrite  = 1'b1;
                decNext.isJalr    = 1'b1;
                decNext.resultSel = selPc4;
            end
            opBranch: begin
                decNext.isBranch = 1'b1;
                decNext.imm      = immB;
            end
            default: ; // Unknown opcode passes through as a no-op
        endcase
    end

    // ============================================================
    // Output register
    // ============================================================
    assign instrReady = !decValid || decReady;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            decValid <= 1'b0;
        end else if (instrReady) begin
            decValid <= instrValid;
        end
    end

    always_ff @(posedge clk) begin
        if (instrValid && instrReady) begin
            dec <= decNext;
        end
    end

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# Compile and run the decode/execute testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f files.f --top-module decExTb -o decExSim \
    && ./obj_dir/decExSim | tee sim.log \
    || echo "Build or simulation failed"

# Pass only if the testbench printed its pass line
grep -qx "No errors" sim.log && echo "PASS" && exit 0 || { echo "FAIL"; exit 1; }

// ==== rvPipePkg.sv ====
package rvPipePkg;

    // ============================================================
    // Widths
    // ============================================================
    localparam int xlen     = 32;
    localparam int regAddrW = 5;

    // ============================================================
    // Major opcodes (RV32I subset)
    // ============================================================
    localparam logic [6:0] opR      = 7'b0110011;
    localparam logic [6:0] opImm    = 7'b0010011;
    localparam logic [6:0] opLui    = 7'b0110111;
    localparam logic [6:0] opAuipc  = 7'b0010111;
    localparam logic [6:0] opJal    = 7'b1101111;
    localparam logic [6:0] opJalr   = 7'b1100111;
    localparam logic [6:0] opBranch = 7'b1100011;

    // ALU operation codes
    localparam logic [3:0] aluAdd  = 4'd0;
    localparam logic [3:0] aluSub  = 4'd1;
    localparam logic [3:0] aluSll  = 4'd2;
    localparam logic [3:0] aluSlt  = 4'd3;
    localparam logic [3:0] aluSltu = 4'd4;
    localparam logic [3:0] aluXor  = 4'd5;
    localparam logic [3:0] aluSrl  = 4'd6;
    localparam logic [3:0] aluSra  = 4'd7;
    localparam logic [3:0] aluOr   = 4'd8;
    localparam logic [3:0] aluAnd  = 4'd9;

    // Write-back source select
    localparam logic [1:0] selAlu = 2'd0;
    localparam logic [1:0] selPc4 = 2'd1; // Link value for JAL/JALR
    localparam logic [1:0] selImm = 2'd2; // LUI and AUIPC

    // ============================================================
    // Instruction word, two layouts over the same 32 bits
    // ============================================================
    typedef struct packed {
        logic [6:0]          funct7;
        logic [regAddrW-1:0] rs2;
        logic [regAddrW-1:0] rs1;
        logic [2:0]          funct3;
        logic [regAddrW-1:0] rd;
        logic [6:0]          opcode;
    } rTypeT;

    typedef struct packed {
        logic [11:0]         imm12;
        logic [regAddrW-1:0] rs1;
        logic [2:0]          funct3;
        logic [regAddrW-1:0] rd;
        logic [6:0]          opcode;
    } iTypeT;

    typedef union packed {
        rTypeT r;   // Register and ALU fields
        iTypeT i;   // Immediate bits
    } instrWordT;

    // ============================================================
    // Stream packets
    // ============================================================
    typedef struct packed {
        instrWordT       word;
        logic [xlen-1:0] pc;
        logic [xlen-1:0] rs1Val;
        logic [xlen-1:0] rs2Val;
    } fetchPktT;

    typedef struct packed {
        logic [xlen-1:0]     pc;
        logic [regAddrW-1:0] rd;
        logic [3:0]          aluOp;
        logic                aluSrcImm;
        logic                regWrite;
        logic                isBranch;
        logic [2:0]          branchFunct3;
        logic                isJal;
        logic                isJalr;
        logic [1:0]          resultSel;
        logic [xlen-1:0]     rs1Val;
        logic [xlen-1:0]     rs2Val;
        logic [xlen-1:0]     imm;
        logic [xlen-1:0]     pcPlus4;
    } decPktT;

    typedef struct packed {
        logic [xlen-1:0]     pc;
        logic [regAddrW-1:0] rd;
        logic [xlen-1:0]     value;
        logic                regWrite;
    } resultPktT;

endpackage
